// ==== logic/jtag_pkg.sv ====
// shared types for the JTAG TAP
// state codes, control flags, register select, opcodes and word widths
package jtag_pkg;

    // scan path lengths
    localparam int IR_LEN = 4;
    localparam int DR_LEN = 32;

    typedef logic [IR_LEN-1:0] ir_word_t;
    typedef logic [DR_LEN-1:0] dr_word_t;

    // instruction opcodes
    localparam ir_word_t INSTR_IDCODE    = 4'h5;
    localparam ir_word_t INSTR_USER_DATA = 4'hD;
    localparam ir_word_t INSTR_BYPASS    = 4'hF;

    // power-on values of the data registers
    localparam dr_word_t JTAG_ID_DEFAULT    = 32'h12345678;
    localparam dr_word_t USER_RESET_DEFAULT = 32'h0A0B0C0D;

    // 16 TAP states, 6-bit code so the LEDs show it directly
    typedef enum logic [5:0] {
        TEST_LOGIC_RESET = 6'd0,
        RUN_TEST_IDLE    = 6'd1,
        SELECT_DR_SCAN   = 6'd2,
        CAPTURE_DR       = 6'd3,
        SHIFT_DR         = 6'd4,
        EXIT1_DR         = 6'd5,
        PAUSE_DR         = 6'd6,
        EXIT2_DR         = 6'd7,
        UPDATE_DR        = 6'd8,
        SELECT_IR_SCAN   = 6'd9,
        CAPTURE_IR       = 6'd10,
        SHIFT_IR         = 6'd11,
        EXIT1_IR         = 6'd12,
        PAUSE_IR         = 6'd13,
        EXIT2_IR         = 6'd14,
        UPDATE_IR        = 6'd15
    } tap_state_e;

    // per-state levels, valid for the whole cycle spent in the state
    typedef struct packed {
        tap_state_e state;
        logic       test_logic_reset;
        logic       capture_dr;
        logic       shift_dr;
        logic       update_dr;
        logic       capture_ir;
        logic       shift_ir;
        logic       update_ir;
    } tap_ctrl_t;

    // which data register sits between tdi and tdo
    typedef enum logic [1:0] {
        SEL_IDCODE = 2'd0,
        SEL_USER   = 2'd1,
        SEL_BYPASS = 2'd2
    } dr_select_e;

endpackage

// ==== logic/scan_register.sv ====
// capture and shift stage, generic over the payload type
module scan_register #(
    parameter type payload_t = logic [7:0]
)
(
    input  logic     jtag_clk,
    input  logic     sys_rst_n,
    input  logic     capture,
    input  logic     shift,
    input  payload_t capture_value,
    input  logic     tdi,
    output payload_t value,
    output logic     tdo_bit
);

    localparam int WIDTH = $bits(payload_t);

    // flat view of the payload so any packed type can shift
    logic [WIDTH-1:0] bits_q;

    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            bits_q  <= '0;
            tdo_bit <= 1'b0;
        end
        else if (capture)
        begin
            bits_q <= capture_value;
        end
        else if (shift)
        begin
            // lsb leaves first, saved for the falling-edge output
            tdo_bit <= bits_q[0];
            bits_q  <= {tdi, bits_q[WIDTH-1:1]};
        end
    end

    // parallel word for the owner's update
    assign value = payload_t'(bits_q);

endmodule

// ==== logic/tap_controller.sv ====
// TAP state machine stepped by tms
// decodes the current state into the control flags
module tap_controller import jtag_pkg::*;
(
    input  logic      jtag_clk,
    input  logic      sys_rst_n,
    input  logic      jtag_tms,
    output tap_ctrl_t ctrl
);

    tap_state_e state_q;
    tap_state_e state_d;

    // state register
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            state_q <= TEST_LOGIC_RESET;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // IEEE 1149.1 successor table
    always_comb
    begin
        case (state_q)
            TEST_LOGIC_RESET: state_d = jtag_tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            // DR column
            SELECT_DR_SCAN:   state_d = jtag_tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       state_d = jtag_tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         state_d = jtag_tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         state_d = jtag_tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         state_d = jtag_tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         state_d = jtag_tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        state_d = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            // IR column, tms high out of select goes back to reset
            SELECT_IR_SCAN:   state_d = jtag_tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = jtag_tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         state_d = jtag_tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         state_d = jtag_tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         state_d = jtag_tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         state_d = jtag_tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        state_d = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            // unused codes fall back to reset
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    // flag decode, the only place that looks at the state code
    always_comb
    begin
        ctrl.state            = state_q;
        ctrl.test_logic_reset = (state_q == TEST_LOGIC_RESET);
        ctrl.capture_dr       = (state_q == CAPTURE_DR);
        ctrl.shift_dr         = (state_q == SHIFT_DR);
        ctrl.update_dr        = (state_q == UPDATE_DR);
        ctrl.capture_ir       = (state_q == CAPTURE_IR);
        ctrl.shift_ir         = (state_q == SHIFT_IR);
        ctrl.update_ir        = (state_q == UPDATE_IR);
    end

endmodule

// ==== logic/instruction_register.sv ====
// instruction scan stage, holding register and opcode decode
module instruction_register import jtag_pkg::*;
(
    input  logic       jtag_clk,
    input  logic       sys_rst_n,
    input  tap_ctrl_t  ctrl,
    input  logic       jtag_tdi,
    output dr_select_e dr_select,
    output logic       ir_tdo
);

    ir_word_t ir_scan;
    ir_word_t ir_hold;

    // scan stage captures the current instruction
    scan_register #(
        .payload_t (ir_word_t)
    ) i_ir_scan (
        .jtag_clk      (jtag_clk),
        .sys_rst_n     (sys_rst_n),
        .capture       (ctrl.capture_ir),
        .shift         (ctrl.shift_ir),
        .capture_value (ir_hold),
        .tdi           (jtag_tdi),
        .value         (ir_scan),
        .tdo_bit       (ir_tdo)
    );

    // holding register, IDCODE whenever the TAP sits in reset
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n || ctrl.test_logic_reset)
        begin
            ir_hold <= INSTR_IDCODE;
        end
        else if (ctrl.update_ir)
        begin
            ir_hold <= ir_scan;
        end
    end

    // opcode decode
    always_comb
    begin
        case (ir_hold)
            INSTR_IDCODE:    dr_select = SEL_IDCODE;
            INSTR_USER_DATA: dr_select = SEL_USER;
            INSTR_BYPASS:    dr_select = SEL_BYPASS;
            // unknown opcodes behave as bypass
            default:         dr_select = SEL_BYPASS;
        endcase
    end

endmodule

// ==== logic/data_register_bank.sv ====
// ID, user and bypass registers
// one shared 32-bit scan stage for ID and user
module data_register_bank import jtag_pkg::*; #(
    parameter dr_word_t JTAG_ID          = JTAG_ID_DEFAULT,
    parameter dr_word_t USER_RESET_VALUE = USER_RESET_DEFAULT
)
(
    input  logic       jtag_clk,
    input  logic       sys_rst_n,
    input  tap_ctrl_t  ctrl,
    input  dr_select_e dr_select,
    input  logic       jtag_tdi,
    output logic       dr_tdo
);

    dr_word_t id_reg;
    dr_word_t user_reg;
    dr_word_t capture_word;
    dr_word_t scan_word;
    logic     bypass_path;
    logic     scan_tdo;
    logic     bypass_bit;
    logic     bypass_tdo;

    assign bypass_path = (dr_select == SEL_BYPASS);

    // word presented to the scan stage on capture
    assign capture_word = (dr_select == SEL_USER) ? user_reg : id_reg;

    // shared stage only runs when a 32-bit register is selected
    scan_register #(
        .payload_t (dr_word_t)
    ) i_dr_scan (
        .jtag_clk      (jtag_clk),
        .sys_rst_n     (sys_rst_n),
        .capture       (ctrl.capture_dr && !bypass_path),
        .shift         (ctrl.shift_dr && !bypass_path),
        .capture_value (capture_word),
        .tdi           (jtag_tdi),
        .value         (scan_word),
        .tdo_bit       (scan_tdo)
    );

    // single bypass flop
    // capture leaves its stored bit in place
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            bypass_bit <= 1'b0;
            bypass_tdo <= 1'b0;
        end
        else if (bypass_path && ctrl.shift_dr)
        begin
            bypass_tdo <= bypass_bit;
            bypass_bit <= jtag_tdi;
        end
    end

    // update writes back into the selected register
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            id_reg   <= JTAG_ID;
            user_reg <= USER_RESET_VALUE;
        end
        else if (ctrl.update_dr && dr_select == SEL_IDCODE)
        begin
            id_reg <= scan_word;
        end
        else if (ctrl.update_dr && dr_select == SEL_USER)
        begin
            user_reg <= scan_word;
        end
    end

    // saved bit of whichever path is active
    assign dr_tdo = bypass_path ? bypass_tdo : scan_tdo;

endmodule

// ==== logic/tdo_driver.sv ====
// falling-edge tdo stage
module tdo_driver import jtag_pkg::*;
(
    input  logic      jtag_clk,
    input  logic      sys_rst_n,
    input  tap_ctrl_t ctrl,
    input  logic      ir_tdo,
    input  logic      dr_tdo,
    output logic      jtag_tdo
);

    logic shifted_ir;
    logic shifted_dr;

    // remember which path the last rising edge shifted
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            shifted_ir <= 1'b0;
            shifted_dr <= 1'b0;
        end
        else
        begin
            shifted_ir <= ctrl.shift_ir;
            shifted_dr <= ctrl.shift_dr;
        end
    end

    // half a cycle later the saved bit goes out, else tdo holds
    always_ff @(negedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            jtag_tdo <= 1'b0;
        end
        else if (shifted_ir)
        begin
            jtag_tdo <= ir_tdo;
        end
        else if (shifted_dr)
        begin
            jtag_tdo <= dr_tdo;
        end
    end

endmodule

// ==== logic/jtag_tap_top.sv ====
// JTAG TAP top level
// controller, IR and DR paths, tdo stage and state LEDs
module jtag_tap_top import jtag_pkg::*; #(
    parameter dr_word_t JTAG_ID          = JTAG_ID_DEFAULT,
    parameter dr_word_t USER_RESET_VALUE = USER_RESET_DEFAULT
)
(
    input  logic       jtag_clk,
    input  logic       sys_rst_n,
    input  logic       jtag_tms,
    input  logic       jtag_tdi,
    output logic       jtag_tdo,
    output logic [5:0] led
);

    tap_ctrl_t  ctrl;
    dr_select_e dr_select;
    logic       ir_tdo;
    logic       dr_tdo;

    tap_controller i_tap_controller (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .ctrl      (ctrl)
    );

    instruction_register i_instruction_register (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .ctrl      (ctrl),
        .jtag_tdi  (jtag_tdi),
        .dr_select (dr_select),
        .ir_tdo    (ir_tdo)
    );

    data_register_bank #(
        .JTAG_ID          (JTAG_ID),
        .USER_RESET_VALUE (USER_RESET_VALUE)
    ) i_data_register_bank (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .ctrl      (ctrl),
        .dr_select (dr_select),
        .jtag_tdi  (jtag_tdi),
        .dr_tdo    (dr_tdo)
    );

    tdo_driver i_tdo_driver (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .ctrl      (ctrl),
        .ir_tdo    (ir_tdo),
        .dr_tdo    (dr_tdo),
        .jtag_tdo  (jtag_tdo)
    );

    // LEDs are active low, lit bits show the state code
    assign led = ~ctrl.state;

endmodule

// ==== testbench/jtag_tap_model.svh ====
// reference model of the TAP, stepped once per rising jtag_clk edge
// predicts state, instruction and data registers and the tdo bit
tap_state_e exp_state;
ir_word_t   exp_ir_scan;
ir_word_t   exp_ir_hold;
dr_word_t   exp_dr_scan;
dr_word_t   exp_id;
dr_word_t   exp_user;
logic       exp_bypass;
// value tdo takes at the falling edge after the last modeled edge
logic       exp_tdo;
// last modeled edge shifted a bit out
logic       exp_last_shift;

// IEEE 1149.1 state diagram
function automatic tap_state_e tap_successor(input tap_state_e s, input logic tms);
    case (s)
        TEST_LOGIC_RESET: return tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
        RUN_TEST_IDLE:    return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
        SELECT_DR_SCAN:   return tms ? SELECT_IR_SCAN : CAPTURE_DR;
        CAPTURE_DR:       return tms ? EXIT1_DR : SHIFT_DR;
        SHIFT_DR:         return tms ? EXIT1_DR : SHIFT_DR;
        EXIT1_DR:         return tms ? UPDATE_DR : PAUSE_DR;
        PAUSE_DR:         return tms ? EXIT2_DR : PAUSE_DR;
        EXIT2_DR:         return tms ? UPDATE_DR : SHIFT_DR;
        UPDATE_DR:        return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
        SELECT_IR_SCAN:   return tms ? TEST_LOGIC_RESET : CAPTURE_IR;
        CAPTURE_IR:       return tms ? EXIT1_IR : SHIFT_IR;
        SHIFT_IR:         return tms ? EXIT1_IR : SHIFT_IR;
        EXIT1_IR:         return tms ? UPDATE_IR : PAUSE_IR;
        PAUSE_IR:         return tms ? EXIT2_IR : PAUSE_IR;
        EXIT2_IR:         return tms ? UPDATE_IR : SHIFT_IR;
        default:          return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
    endcase
endfunction

task automatic reset_model();
    exp_state      = TEST_LOGIC_RESET;
    exp_ir_scan    = '0;
    exp_ir_hold    = INSTR_IDCODE;
    exp_dr_scan    = '0;
    exp_id         = JTAG_ID_DEFAULT;
    exp_user       = USER_RESET_DEFAULT;
    exp_bypass     = 1'b0;
    exp_tdo        = 1'b0;
    exp_last_shift = 1'b0;
endtask

// actions belong to the state the TAP is in before the edge
task automatic advance_model(input logic tms, input logic tdi);
    dr_select_e sel;
    // unknown opcodes fall to bypass
    sel = (exp_ir_hold == INSTR_IDCODE) ? SEL_IDCODE
        : (exp_ir_hold == INSTR_USER_DATA) ? SEL_USER : SEL_BYPASS;
    exp_last_shift = (exp_state == SHIFT_IR) || (exp_state == SHIFT_DR);
    case (exp_state)
        TEST_LOGIC_RESET: exp_ir_hold = INSTR_IDCODE;
        CAPTURE_IR:       exp_ir_scan = exp_ir_hold;
        UPDATE_IR:        exp_ir_hold = exp_ir_scan;
        SHIFT_IR:
        begin
            exp_tdo     = exp_ir_scan[0];
            exp_ir_scan = {tdi, exp_ir_scan[IR_LEN-1:1]};
        end
        // bypass keeps whatever bit it holds
        CAPTURE_DR: exp_dr_scan = (sel == SEL_USER) ? exp_user
                                : (sel == SEL_IDCODE) ? exp_id : exp_dr_scan;
        SHIFT_DR:
        begin
            if (sel == SEL_BYPASS)
            begin
                exp_tdo    = exp_bypass;
                exp_bypass = tdi;
            end
            else
            begin
                exp_tdo     = exp_dr_scan[0];
                exp_dr_scan = {tdi, exp_dr_scan[DR_LEN-1:1]};
            end
        end
        UPDATE_DR:
        begin
            exp_id   = (sel == SEL_IDCODE) ? exp_dr_scan : exp_id;
            exp_user = (sel == SEL_USER) ? exp_dr_scan : exp_user;
        end
        default: ;
    endcase
    exp_state = tap_successor(exp_state, tms);
endtask

// ==== testbench/tb_jtag_tap.sv ====
// JTAG TAP testbench with random tms and tdi from a fixed seed
// per-cycle model compare plus directed IDCODE, user and bypass scans
module tb_jtag_tap import jtag_pkg::*;
();

    localparam logic [31:0] SEED           = 32'h8058_0798;
    localparam ir_word_t    UNKNOWN_OPCODE = 4'h3;

    logic       jtag_clk = 1'b0;
    logic       sys_rst_n;
    logic       jtag_tms;
    logic       jtag_tdi;
    logic       jtag_tdo;
    logic [5:0] led;

    // tdo bits of the current scan in lsb-first order
    dr_word_t collected;
    int       collected_n;

    `include "jtag_tap_model.svh"

    jtag_tap_top i_dut (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .jtag_tdi  (jtag_tdi),
        .jtag_tdo  (jtag_tdo),
        .led       (led)
    );

    always #4 jtag_clk = ~jtag_clk;

    task automatic stop_with_failure(input string reason);
        $display("sim failed");
        $fatal(1, "%s", reason);
    endtask

    // led is active low so its inverse is the state code
    task automatic check_state(input tap_state_e expected);
        tap_state_e got;
        got = tap_state_e'(~led);
        if (got !== expected)
        begin
            $display("mismatch at %0t: led shows %s, expected %s",
                     $time, got.name(), expected.name());
            stop_with_failure("TAP state differs from the model");
        end
    endtask

    task automatic check_bit(input logic expected, input string what);
        if (jtag_tdo !== expected)
        begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, jtag_tdo, expected);
            stop_with_failure("tdo differs from the model");
        end
    endtask

    task automatic check_word(input dr_word_t expected, input dr_word_t got, input string what);
        if (got !== expected)
        begin
            $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, expected);
            stop_with_failure("scanned word differs from the expected value");
        end
    endtask

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $urandom();
        return r[0];
    endfunction

    function automatic dr_word_t rand_word();
        return dr_word_t'($urandom());
    endfunction

    // one jtag_clk period from rising edge to rising edge
    // led checked mid-cycle and tdo at the closing rising edge
    task automatic run_cycle(input logic tms, input logic tdi);
        jtag_tms <= tms;
        jtag_tdi <= tdi;
        @(negedge jtag_clk);
        check_state(exp_state);
        @(posedge jtag_clk);
        check_bit(exp_tdo, "tdo");
        if (exp_last_shift && collected_n < DR_LEN)
        begin
            collected = collected | (dr_word_t'(jtag_tdo) << collected_n);
            collected_n++;
        end
        advance_model(tms, tdi);
    endtask

    // five tms ones reach test-logic-reset from any state
    task automatic goto_reset();
        repeat (5)
        begin
            run_cycle(1'b1, rand_bit());
        end
    endtask

    task automatic goto_idle();
        goto_reset();
        run_cycle(1'b0, 1'b0);
    endtask

    // IR or DR scan from run-test/idle back to run-test/idle
    // pauses leave shift through exit1 and return through exit2
    task automatic scan(input logic is_ir, input int len, input dr_word_t din,
                        input logic pauses, output dr_word_t dout);
        dr_word_t pending;
        int       sent;
        pending     = din;
        sent        = 0;
        collected   = '0;
        collected_n = 0;
        run_cycle(1'b1, 1'b0);
        if (is_ir)
        begin
            run_cycle(1'b1, 1'b0);
        end
        // through capture into shift
        run_cycle(1'b0, 1'b0);
        run_cycle(1'b0, 1'b0);
        while (sent < len)
        begin
            if (pauses && sent < len - 1 && $urandom() % 6 == 0)
            begin
                run_cycle(1'b1, pending[0]);
                run_cycle(1'b0, rand_bit());
                repeat (1 + $urandom() % 3)
                begin
                    run_cycle(1'b0, rand_bit());
                end
                run_cycle(1'b1, rand_bit());
                run_cycle(1'b0, rand_bit());
            end
            else
            begin
                run_cycle(sent == len - 1, pending[0]);
            end
            pending = pending >> 1;
            sent++;
        end
        // last bit shows up while passing through update
        run_cycle(1'b1, 1'b0);
        run_cycle(1'b0, 1'b0);
        dout = collected;
    endtask

    initial
    begin
        dr_word_t word_a;
        dr_word_t word_b;
        dr_word_t got;
        logic     is_ir;
        int       len;
        void'($urandom(SEED));
        sys_rst_n <= 1'b0;
        jtag_tms  <= 1'b1;
        jtag_tdi  <= 1'b0;
        repeat (10)
        begin
            @(posedge jtag_clk);
        end
        sys_rst_n <= 1'b1;
        reset_model();
        check_bit(1'b0, "tdo after reset");
        run_cycle(1'b1, 1'b0);
        run_cycle(1'b1, 1'b0);

        // IDCODE comes out lsb first straight after reset
        goto_idle();
        scan(1'b0, DR_LEN, rand_word(), 1'b0, got);
        check_word(JTAG_ID_DEFAULT, got, "idcode scan");

        // user register returns its reset value and then the word written in
        scan(1'b1, IR_LEN, dr_word_t'(INSTR_USER_DATA), 1'b0, got);
        check_word(dr_word_t'(INSTR_IDCODE), got, "ir scan after reset");
        word_a = rand_word();
        scan(1'b0, DR_LEN, word_a, 1'b0, got);
        check_word(USER_RESET_DEFAULT, got, "user scan 1");
        word_b = rand_word();
        scan(1'b0, DR_LEN, word_b, 1'b0, got);
        check_word(word_a, got, "user scan 2");

        // bypass delays tdi by one bit and starts with a 0
        scan(1'b1, IR_LEN, dr_word_t'(INSTR_BYPASS), 1'b0, got);
        check_word(dr_word_t'(INSTR_USER_DATA), got, "ir scan user");
        word_a = rand_word();
        word_a[DR_LEN-1] = 1'b0;
        scan(1'b0, DR_LEN, word_a, 1'b0, got);
        check_word({word_a[DR_LEN-2:0], 1'b0}, got, "bypass scan");
        scan(1'b1, IR_LEN, dr_word_t'(UNKNOWN_OPCODE), 1'b0, got);
        check_word(dr_word_t'(INSTR_BYPASS), got, "ir scan bypass");
        word_b = rand_word();
        scan(1'b0, DR_LEN, word_b, 1'b0, got);
        check_word({word_b[DR_LEN-2:0], 1'b0}, got, "unknown opcode scan");
        scan(1'b1, IR_LEN, dr_word_t'(INSTR_IDCODE), 1'b0, got);
        check_word(dr_word_t'(UNKNOWN_OPCODE), got, "ir scan unknown");

        // wander to a random state and return with five tms ones
        repeat (3 + $urandom() % 12)
        begin
            run_cycle(rand_bit(), rand_bit());
        end
        goto_reset();

        // led follows the model under free-running random tms
        repeat (300)
        begin
            run_cycle(rand_bit(), rand_bit());
        end

        // mixed scans with pauses and tdo compared every cycle
        goto_idle();
        repeat (24)
        begin
            is_ir = rand_bit();
            len   = is_ir ? IR_LEN : 1 + int'($urandom() % DR_LEN);
            scan(is_ir, len, rand_word(), 1'b1, got);
        end

        goto_reset();
        run_cycle(1'b1, 1'b0);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+testbench
logic/jtag_pkg.sv
logic/scan_register.sv
logic/tap_controller.sv
logic/instruction_register.sv
logic/data_register_bank.sv
logic/tdo_driver.sv
logic/jtag_tap_top.sv
testbench/tb_jtag_tap.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_jtag_tap
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard testbench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the verdict
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
